// ==== include/sha256_defs.svh ====
// Bus widths, identification constants and register byte offsets of the SHA-256 block
// Included by the register file and the top level

`ifndef SHA256_DEFS_SVH
`define SHA256_DEFS_SVH

// Bus widths
`define SHA256_ADDR_WIDTH 32
`define SHA256_DATA_WIDTH 32

// Read-only identification words
`define SHA256_NAME0    32'h73686132
`define SHA256_NAME1    32'h2d323536
`define SHA256_VERSION0 32'h312e3030
`define SHA256_VERSION1 32'h00000000

// Register byte offsets inside the 256-byte window
`define SHA256_OFF_NAME    8'h00
`define SHA256_OFF_VERSION 8'h08
`define SHA256_OFF_CTRL    8'h10
`define SHA256_OFF_STATUS  8'h14
`define SHA256_OFF_INTR    8'h18
`define SHA256_OFF_BLOCK   8'h40
`define SHA256_OFF_DIGEST  8'h80

`endif

// ==== hw/sha256_core_pkg.sv ====
// Algorithm constants and the hash state type for the SHA-224/SHA-256 engine
// Imported by the core, the message schedule, the register file and the top level
package sha256_core_pkg;

  // Eight 32-bit words, word 0 is the most significant one
  typedef logic [0:7][31:0] hash_state_t;

  // Round constants K[0..63]
  localparam logic [31:0] round_k [64] = '{
    32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
    32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
    32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
    32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
    32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
    32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
    32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
    32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
    32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
    32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
    32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
    32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
    32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
    32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
    32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
    32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
  };

  // Initial hash values, SHA-256 and SHA-224
  localparam hash_state_t h0_sha256 = {
    32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
    32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
  };
  localparam hash_state_t h0_sha224 = {
    32'hc1059ed8, 32'h367cd507, 32'h3070dd17, 32'hf70e5939,
    32'hffc00b31, 32'h68581511, 32'h64f98fa7, 32'hbefa4fa4
  };

  // Right rotate of a word, n is 1..31
  function automatic logic [31:0] rotr(input logic [31:0] x, input int unsigned n);
    return (x >> n) | (x << (32 - n));
  endfunction

endpackage

// ==== hw/sha256_reg_pkg.sv ====
// Register map types of the SHA-256 block, bit positions and decoder kinds
// Imported by the register file and by the bench checker
package sha256_reg_pkg;

  // CTRL bit positions, MODE high selects SHA-256
  typedef enum int unsigned {
    CTRL_INIT    = 0,
    CTRL_NEXT    = 1,
    CTRL_MODE    = 2,
    CTRL_ZEROIZE = 3
  } ctrl_bit_e;

  // STATUS bit positions
  typedef enum int unsigned {
    STATUS_READY = 0,
    STATUS_VALID = 1
  } status_bit_e;

  // INTR bit positions, both sticky, write 1 to clear
  typedef enum int unsigned {
    INTR_NOTIF = 0,
    INTR_ERROR = 1
  } intr_bit_e;

  // Address decoder result
  typedef enum logic [2:0] {
    REG_NONE,
    REG_NAME,
    REG_VERSION,
    REG_CTRL,
    REG_STATUS,
    REG_INTR,
    REG_BLOCK,
    REG_DIGEST
  } reg_kind_e;

endpackage

// ==== hw/sha256_w_mem.sv ====
// SHA-256 message schedule, a sixteen word sliding window
// Loaded with the block on init, gives one schedule word per round on next
`timescale 1ns/1ps

module sha256_w_mem (
  input  logic         clk,
  input  logic         reset_n,
  input  logic         init,
  input  logic         next,
  input  logic [511:0] block,
  output logic [31:0]  w
);

  import sha256_core_pkg::*;

  // ------------------------------
  // Window and expansion
  // ------------------------------
  // window[0] is W[t], window[15] is W[t+15]
  logic [31:0] window [16];
  logic [31:0] sig0;
  logic [31:0] sig1;
  logic [31:0] w_new;

  // W[t+16] = s1(W[t+14]) + W[t+9] + s0(W[t+1]) + W[t]
  always_comb begin
    sig0 = rotr(window[1], 7) ^ rotr(window[1], 18) ^ (window[1] >> 3);
    sig1 = rotr(window[14], 17) ^ rotr(window[14], 19) ^ (window[14] >> 10);
    w_new = sig1 + window[9] + sig0 + window[0];
  end

  // ------------------------------
  // Shift register
  // ------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < 16; i++) begin
        window[i] <= '0;
      end
    end else if (init) begin
      // Block word 0 sits in the top bits
      for (int i = 0; i < 16; i++) begin
        window[i] <= block[511 - 32*i -: 32];
      end
    end else if (next) begin
      for (int i = 0; i < 15; i++) begin
        window[i] <= window[i + 1];
      end
      window[15] <= w_new;
    end
  end

  // Rounds 0..15 see the block words, later rounds the expanded ones
  assign w = window[0];

endmodule

// ==== hw/sha256_core.sv ====
// SHA-224/SHA-256 compression engine, one round per clock
// Takes init or next while ready, reports digest_valid after 66 cycles
`timescale 1ns/1ps

module sha256_core (
  input  logic                        clk,
  input  logic                        reset_n,
  input  logic                        zeroize,
  input  logic                        init,
  input  logic                        next,
  input  logic                        mode,
  input  logic [511:0]                block,
  output logic                        ready,
  output logic                        digest_valid,
  output sha256_core_pkg::hash_state_t digest
);

  import sha256_core_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ROUNDS,
    ST_DONE
  } state_e;

  state_e      state;
  logic [5:0]  round_ctr;
  logic        mode_q;
  logic        start;
  logic [31:0] w;

  // Chaining state and working variables a..h in words 0..7
  hash_state_t h_reg;
  hash_state_t work;
  hash_state_t h_init;

  // Round terms
  logic [31:0] big_s0;
  logic [31:0] big_s1;
  logic [31:0] ch;
  logic [31:0] maj;
  logic [31:0] t1;
  logic [31:0] t2;

  // Commands are dropped while a hash is running
  assign start = ready && (init || next) && !zeroize;

  assign h_init = mode ? h0_sha256 : h0_sha224;

  sha256_w_mem w_mem_inst (
    .clk     (clk),
    .reset_n (reset_n),
    .init    (start),
    .next    (state == ST_ROUNDS),
    .block   (block),
    .w       (w)
  );

  // ------------------------------
  // Compression round
  // ------------------------------
  always_comb begin
    big_s1 = rotr(work[4], 6) ^ rotr(work[4], 11) ^ rotr(work[4], 25);
    ch     = (work[4] & work[5]) ^ (~work[4] & work[6]);
    t1     = work[7] + big_s1 + ch + round_k[round_ctr] + w;
    big_s0 = rotr(work[0], 2) ^ rotr(work[0], 13) ^ rotr(work[0], 22);
    maj    = (work[0] & work[1]) ^ (work[0] & work[2]) ^ (work[1] & work[2]);
    t2     = big_s0 + maj;
  end

  // ------------------------------
  // Control FSM
  // ------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state        <= ST_IDLE;
      round_ctr    <= '0;
      mode_q       <= 1'b0;
      ready        <= 1'b1;
      digest_valid <= 1'b0;
    end else if (zeroize) begin
      // Abort, idle again on the next edge
      state        <= ST_IDLE;
      round_ctr    <= '0;
      mode_q       <= 1'b0;
      ready        <= 1'b1;
      digest_valid <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start) begin
            state        <= ST_ROUNDS;
            round_ctr    <= '0;
            mode_q       <= mode;
            ready        <= 1'b0;
            digest_valid <= 1'b0;
          end
        end
        ST_ROUNDS: begin
          round_ctr <= round_ctr + 6'd1;
          if (round_ctr == 6'd63) begin
            state <= ST_DONE;
          end
        end
        ST_DONE: begin
          state        <= ST_IDLE;
          ready        <= 1'b1;
          digest_valid <= 1'b1;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // ------------------------------
  // Datapath
  // ------------------------------
  always_ff @(posedge clk) begin
    if (zeroize) begin
      h_reg <= '0;
      work  <= '0;
    end else if (start) begin
      // init reseeds the chain, next continues from the prior digest
      if (init) begin
        h_reg <= h_init;
        work  <= h_init;
      end else begin
        work <= h_reg;
      end
    end else if (state == ST_ROUNDS) begin
      work <= {t1 + t2, work[0], work[1], work[2],
               work[3] + t1, work[4], work[5], work[6]};
    end else if (state == ST_DONE) begin
      for (int i = 0; i < 8; i++) begin
        h_reg[i] <= h_reg[i] + work[i];
      end
    end
  end

  // SHA-224 drops the last word
  always_comb begin
    digest = h_reg;
    if (!mode_q) begin
      digest[7] = '0;
    end
  end

endmodule

// ==== hw/sha256_regs.sv ====
// Register file of the SHA-256 block with a single-cycle cs/we bus
// Decodes the map, holds block and digest words, status and sticky interrupts
`timescale 1ns/1ps
`include "sha256_defs.svh"

module sha256_regs (
  input  logic                          clk,
  input  logic                          reset_n,
  input  logic                          cs,
  input  logic                          we,
  input  logic [`SHA256_ADDR_WIDTH-1:0] address,
  input  logic [`SHA256_DATA_WIDTH-1:0] write_data,
  output logic [`SHA256_DATA_WIDTH-1:0] read_data,
  output logic                          err,
  input  logic                          core_ready,
  input  logic                          core_digest_valid,
  input  sha256_core_pkg::hash_state_t   core_digest,
  output logic                          init,
  output logic                          next,
  output logic                          mode,
  output logic                          zeroize,
  output logic [511:0]                  block,
  output logic                          error_intr,
  output logic                          notif_intr
);

  import sha256_core_pkg::*;
  import sha256_reg_pkg::*;

  reg_kind_e   kind;
  logic        wr_en;
  logic        rd_en;
  logic        ctrl_wr;
  logic        intr_wr;
  logic        ro_hit;
  logic [31:0] block_q [16];
  hash_state_t digest_q;
  logic        ready_q;
  logic        valid_q;
  logic        dv_rise;

  assign wr_en   = cs && we;
  assign rd_en   = cs && !we;
  assign ctrl_wr = wr_en && (kind == REG_CTRL);
  assign intr_wr = wr_en && (kind == REG_INTR);

  // ------------------------------
  // Address decode
  // ------------------------------
  always_comb begin
    kind = REG_NONE;
    // Word aligned and inside the 256-byte window only
    if (address[`SHA256_ADDR_WIDTH-1:8] == '0 && address[1:0] == 2'b00) begin
      if ((address[7:0] & 8'hf8) == `SHA256_OFF_NAME) kind = REG_NAME;
      else if ((address[7:0] & 8'hf8) == `SHA256_OFF_VERSION) kind = REG_VERSION;
      else if (address[7:0] == `SHA256_OFF_CTRL) kind = REG_CTRL;
      else if (address[7:0] == `SHA256_OFF_STATUS) kind = REG_STATUS;
      else if (address[7:0] == `SHA256_OFF_INTR) kind = REG_INTR;
      else if ((address[7:0] & 8'hc0) == `SHA256_OFF_BLOCK) kind = REG_BLOCK;
      else if ((address[7:0] & 8'he0) == `SHA256_OFF_DIGEST) kind = REG_DIGEST;
    end
  end

  // Read-only registers
  assign ro_hit = (kind == REG_NAME) || (kind == REG_VERSION) ||
                  (kind == REG_STATUS) || (kind == REG_DIGEST);
  assign err = cs && ((kind == REG_NONE) || (we && ro_hit));

  // ------------------------------
  // Read mux
  // ------------------------------
  always_comb begin
    read_data = '0;
    if (rd_en) begin
      case (kind)
        REG_NAME:    read_data = address[2] ? `SHA256_NAME1 : `SHA256_NAME0;
        REG_VERSION: read_data = address[2] ? `SHA256_VERSION1 : `SHA256_VERSION0;
        REG_CTRL:    read_data[CTRL_MODE] = mode;
        REG_STATUS: begin
          read_data[STATUS_READY] = ready_q;
          read_data[STATUS_VALID] = valid_q;
        end
        REG_INTR: begin
          read_data[INTR_NOTIF] = notif_intr;
          read_data[INTR_ERROR] = error_intr;
        end
        REG_BLOCK:   read_data = block_q[address[5:2]];
        REG_DIGEST:  read_data = digest_q[address[4:2]];
        default:     read_data = '0;
      endcase
    end
  end

  // ------------------------------
  // Commands and storage
  // ------------------------------
  // New result edge, a zeroize in flight masks it
  assign dv_rise = core_digest_valid && !valid_q && !zeroize;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      init       <= 1'b0;
      next       <= 1'b0;
      zeroize    <= 1'b0;
      mode       <= 1'b0;
      ready_q    <= 1'b1;
      valid_q    <= 1'b0;
      digest_q   <= '0;
      notif_intr <= 1'b0;
      error_intr <= 1'b0;
      for (int i = 0; i < 16; i++) begin
        block_q[i] <= '0;
      end
    end else begin
      // Single-cycle pulses from a CTRL write
      init    <= ctrl_wr && write_data[CTRL_INIT];
      next    <= ctrl_wr && write_data[CTRL_NEXT];
      zeroize <= ctrl_wr && write_data[CTRL_ZEROIZE];
      ready_q <= core_ready;
      if (zeroize) begin
        mode     <= 1'b0;
        valid_q  <= 1'b0;
        digest_q <= '0;
        for (int i = 0; i < 16; i++) begin
          block_q[i] <= '0;
        end
      end else begin
        if (ctrl_wr) mode <= write_data[CTRL_MODE];
        valid_q <= core_digest_valid;
        if (dv_rise) digest_q <= core_digest;
        if (wr_en && kind == REG_BLOCK) block_q[address[5:2]] <= write_data;
      end
      // Sticky, a new event wins over a clear in the same cycle
      notif_intr <= dv_rise || (notif_intr && !(intr_wr && write_data[INTR_NOTIF]));
      error_intr <= err || (error_intr && !(intr_wr && write_data[INTR_ERROR]));
    end
  end

  // BLOCK word 0 goes to the top bits
  always_comb begin
    for (int i = 0; i < 16; i++) begin
      block[511 - 32*i -: 32] = block_q[i];
    end
  end

endmodule

// ==== hw/sha256.sv ====
// Top level of the SHA-224/SHA-256 accelerator
// Register file on the cs/we bus in front of the compression engine
`timescale 1ns/1ps
`include "sha256_defs.svh"

module sha256 (
  input  logic                          clk,
  input  logic                          reset_n,
  input  logic                          cs,
  input  logic                          we,
  input  logic [`SHA256_ADDR_WIDTH-1:0] address,
  input  logic [`SHA256_DATA_WIDTH-1:0] write_data,
  output logic [`SHA256_DATA_WIDTH-1:0] read_data,
  output logic                          err,
  output logic                          error_intr,
  output logic                          notif_intr
);

  import sha256_core_pkg::*;

  // Register file to core
  logic         core_init;
  logic         core_next;
  logic         core_mode;
  logic         core_zeroize;
  logic [511:0] core_block;

  // Core to register file
  logic         core_ready;
  logic         core_digest_valid;
  hash_state_t  core_digest;

  sha256_regs regs_inst (
    .clk               (clk),
    .reset_n           (reset_n),
    .cs                (cs),
    .we                (we),
    .address           (address),
    .write_data        (write_data),
    .read_data         (read_data),
    .err               (err),
    .core_ready        (core_ready),
    .core_digest_valid (core_digest_valid),
    .core_digest       (core_digest),
    .init              (core_init),
    .next              (core_next),
    .mode              (core_mode),
    .zeroize           (core_zeroize),
    .block             (core_block),
    .error_intr        (error_intr),
    .notif_intr        (notif_intr)
  );

  sha256_core core_inst (
    .clk          (clk),
    .reset_n      (reset_n),
    .zeroize      (core_zeroize),
    .init         (core_init),
    .next         (core_next),
    .mode         (core_mode),
    .block        (core_block),
    .ready        (core_ready),
    .digest_valid (core_digest_valid),
    .digest       (core_digest)
  );

endmodule

// ==== bench/sha256_properties.sv ====
// Bus and interrupt assertions on the SHA-256 top level
// Attached to every sha256 instance by the bind at the end of the file
`timescale 1ns/1ps
`include "sha256_defs.svh"

module sha256_properties (
  input logic                          clk,
  input logic                          reset_n,
  input logic                          cs,
  input logic                          we,
  input logic [`SHA256_ADDR_WIDTH-1:0] address,
  input logic [`SHA256_DATA_WIDTH-1:0] write_data,
  input logic [`SHA256_DATA_WIDTH-1:0] read_data,
  input logic                          err,
  input logic                          notif_intr
);

  import sha256_reg_pkg::*;

  // Write of 1 to the NOTIF bit of INTR
  logic notif_clear;
  assign notif_clear = cs && we && (address == {24'd0, `SHA256_OFF_INTR}) &&
                       write_data[INTR_NOTIF];

  err_only_with_cs: assert property (@(posedge clk) disable iff (!reset_n)
    !cs |-> !err)
    else $error("err high while cs is low");

  notif_falls_on_clear: assert property (@(posedge clk) disable iff (!reset_n)
    $fell(notif_intr) |-> $past(notif_clear))
    else $error("notif_intr fell without an INTR clear");

  idle_read_zero: assert property (@(posedge clk) disable iff (!reset_n)
    !cs |-> read_data == '0)
    else $error("read_data nonzero while cs is low");

endmodule

bind sha256 sha256_properties props_inst (.*);

// ==== bench/sha256_checker.sv ====
// Bus monitor with a behavioral SHA-224/SHA-256 model
// Samples on the falling edge and compares every read, err and interrupt level
`timescale 1ns/1ps
`include "sha256_defs.svh"

module sha256_checker (
  input logic                          clk,
  input logic                          reset_n,
  input logic                          cs,
  input logic                          we,
  input logic [`SHA256_ADDR_WIDTH-1:0] address,
  input logic [`SHA256_DATA_WIDTH-1:0] write_data,
  input logic [`SHA256_DATA_WIDTH-1:0] read_data,
  input logic                          err,
  input logic                          error_intr,
  input logic                          notif_intr
);

  import sha256_core_pkg::*;
  import sha256_reg_pkg::*;

  int error_count = 0;

  // Model state
  logic [31:0] blk [16];
  logic [31:0] chain [8];
  logic [31:0] pending [8];
  logic [31:0] shown [8];
  logic        model_mode;
  logic        model_valid;
  logic        model_notif;
  logic        model_error;
  // Cycles since the last command, busy marks a hash in flight
  int          age;
  logic        busy;

  function automatic logic [31:0] ror32(input logic [31:0] x, input int n);
    return (x >> n) | (x << (32 - n));
  endfunction

  // One compression of blk into chain, FIPS 180-4 section 6.2.2
  function automatic void compress_block();
    logic [31:0] w [64];
    logic [31:0] v [8];
    logic [31:0] s0;
    logic [31:0] s1;
    logic [31:0] t1;
    logic [31:0] t2;
    for (int t = 0; t < 64; t++) begin
      if (t < 16) begin
        w[t] = blk[t];
      end else begin
        s0 = ror32(w[t-15], 7) ^ ror32(w[t-15], 18) ^ (w[t-15] >> 3);
        s1 = ror32(w[t-2], 17) ^ ror32(w[t-2], 19) ^ (w[t-2] >> 10);
        w[t] = s1 + w[t-7] + s0 + w[t-16];
      end
    end
    for (int i = 0; i < 8; i++) begin
      v[i] = chain[i];
    end
    for (int t = 0; t < 64; t++) begin
      s1 = ror32(v[4], 6) ^ ror32(v[4], 11) ^ ror32(v[4], 25);
      t1 = v[7] + s1 + ((v[4] & v[5]) ^ (~v[4] & v[6])) + round_k[t] + w[t];
      s0 = ror32(v[0], 2) ^ ror32(v[0], 13) ^ ror32(v[0], 22);
      t2 = s0 + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
      v[7] = v[6];
      v[6] = v[5];
      v[5] = v[4];
      v[4] = v[3] + t1;
      v[3] = v[2];
      v[2] = v[1];
      v[1] = v[0];
      v[0] = t1 + t2;
    end
    for (int i = 0; i < 8; i++) begin
      chain[i] = chain[i] + v[i];
    end
  endfunction

  // 0 none, 1 NAME, 2 VERSION, 3 CTRL, 4 STATUS, 5 INTR, 6 BLOCK, 7 DIGEST
  function automatic int decode_kind(input logic [31:0] a);
    logic [7:0] off;
    off = a[7:0];
    if (a[31:8] != 24'd0 || a[1:0] != 2'b00) return 0;
    if (off < `SHA256_OFF_VERSION) return 1;
    if (off < `SHA256_OFF_CTRL) return 2;
    if (off == `SHA256_OFF_CTRL) return 3;
    if (off == `SHA256_OFF_STATUS) return 4;
    if (off == `SHA256_OFF_INTR) return 5;
    if (off >= `SHA256_OFF_BLOCK && off < `SHA256_OFF_DIGEST) return 6;
    if (off >= `SHA256_OFF_DIGEST && off < 8'ha0) return 7;
    return 0;
  endfunction

  function automatic string reg_name(input int kind, input logic [31:0] a);
    string names [8] = '{"UNMAPPED", "NAME", "VERSION", "CTRL",
                         "STATUS", "INTR", "BLOCK", "DIGEST"};
    return $sformatf("%s@%08h", names[kind], a);
  endfunction

  function automatic void mismatch(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
    error_count++;
    $display("ERR %0t %s expected %08h got %08h", $time, name, exp_v, act_v);
  endfunction

  // CTRL write, either zeroize or a new init/next command
  function automatic void ctrl_write(input logic [31:0] wd);
    if (wd[CTRL_ZEROIZE]) begin
      for (int i = 0; i < 16; i++) blk[i] = '0;
      for (int i = 0; i < 8; i++) begin
        chain[i] = '0;
        shown[i] = '0;
      end
      model_mode  = 1'b0;
      model_valid = 1'b0;
      busy        = 1'b0;
      age         = 0;
    end else begin
      model_mode = wd[CTRL_MODE];
      if ((wd[CTRL_INIT] || wd[CTRL_NEXT]) && !(busy && age < 68)) begin
        if (wd[CTRL_INIT]) begin
          for (int i = 0; i < 8; i++) begin
            chain[i] = model_mode ? h0_sha256[i] : h0_sha224[i];
          end
        end
        compress_block();
        for (int i = 0; i < 8; i++) pending[i] = chain[i];
        // SHA-224 result is seven words
        if (!model_mode) pending[7] = '0;
        busy = 1'b1;
        age  = 0;
      end
    end
  endfunction

  // ------------------------------
  // Falling edge monitor
  // ------------------------------
  always @(negedge clk) begin : monitor
    int          kind;
    logic        exp_err;
    logic        settled;
    logic        check_data;
    logic [31:0] exp_data;
    if (!reset_n) begin
      for (int i = 0; i < 16; i++) blk[i] = '0;
      for (int i = 0; i < 8; i++) begin
        chain[i] = '0;
        shown[i] = '0;
      end
      model_mode  = 1'b0;
      model_valid = 1'b0;
      model_notif = 1'b0;
      model_error = 1'b0;
      busy        = 1'b0;
      age         = 1000;
    end else begin
      if (age < 1000) age++;
      // Result lands 67 edges after the command write
      if (busy && age == 68) begin
        for (int i = 0; i < 8; i++) shown[i] = pending[i];
        model_valid = 1'b1;
        model_notif = 1'b1;
      end
      settled = busy ? (age >= 68) : (age >= 4);
      if (notif_intr !== model_notif) mismatch("notif_intr", 32'(model_notif), 32'(notif_intr));
      if (error_intr !== model_error) mismatch("error_intr", 32'(model_error), 32'(error_intr));
      if (cs) begin
        kind    = decode_kind(address);
        exp_err = (kind == 0) || (we && (kind == 1 || kind == 2 || kind == 4 || kind == 7));
        if (err !== exp_err) mismatch("err", 32'(exp_err), 32'(err));
        if (!we) begin
          check_data = 1'b1;
          exp_data   = '0;
          case (kind)
            1: exp_data = address[2] ? `SHA256_NAME1 : `SHA256_NAME0;
            2: exp_data = address[2] ? `SHA256_VERSION1 : `SHA256_VERSION0;
            3: begin
              exp_data[CTRL_MODE] = model_mode;
              check_data = busy || age >= 4;
            end
            4: begin
              if (busy && age >= 4 && age <= 66) begin
                exp_data = '0;
              end else if (settled) begin
                exp_data[STATUS_READY] = 1'b1;
                exp_data[STATUS_VALID] = model_valid;
              end else begin
                check_data = 1'b0;
              end
            end
            5: begin
              exp_data[INTR_NOTIF] = model_notif;
              exp_data[INTR_ERROR] = model_error;
            end
            6: begin
              exp_data   = blk[address[5:2]];
              check_data = busy || age >= 4;
            end
            7: begin
              exp_data   = shown[address[4:2]];
              check_data = settled;
            end
            default: exp_data = '0;
          endcase
          if (check_data && read_data !== exp_data) begin
            mismatch(reg_name(kind, address), exp_data, read_data);
          end
        end else if (!exp_err) begin
          if (kind == 3) ctrl_write(write_data);
          if (kind == 6) blk[address[5:2]] = write_data;
          if (kind == 5 && write_data[INTR_NOTIF]) model_notif = 1'b0;
          if (kind == 5 && write_data[INTR_ERROR]) model_error = 1'b0;
        end
        if (exp_err) model_error = 1'b1;
      end
    end
  end

endmodule

// ==== bench/sha256_tb.sv ====
// Testbench top for the SHA-224/SHA-256 accelerator
// Drives seeded random traffic over the cs/we bus, the checker does the comparing
`timescale 1ns/1ps
`include "sha256_defs.svh"

module sha256_tb;

  import sha256_reg_pkg::*;

  // Six blocks in test 2, up to 16 in test 3, one each in tests 4 and 6
  localparam int TOTAL_BLOCKS = 24;
  localparam int WATCHDOG_NS  = (TOTAL_BLOCKS * 100 + 3000) * 8;

  logic        clk;
  logic        reset_n;
  logic        cs;
  logic        we;
  logic [31:0] address;
  logic [31:0] write_data;
  logic [31:0] read_data;
  logic        err;
  logic        error_intr;
  logic        notif_intr;

  int          tests_passed = 0;
  int          tests_failed = 0;
  int          local_errors = 0;
  int          errors_before;
  int unsigned seed_value;

  always #4 clk = ~clk;

  sha256 sha256_inst (.*);

  sha256_checker checker_inst (.*);

  // ------------------------------
  // Bus tasks
  // ------------------------------
  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk);
    cs         <= 1'b1;
    we         <= 1'b1;
    address    <= addr;
    write_data <= data;
    @(posedge clk);
    cs <= 1'b0;
    we <= 1'b0;
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
    @(posedge clk);
    cs      <= 1'b1;
    we      <= 1'b0;
    address <= addr;
    @(negedge clk);
    data = read_data;
    @(posedge clk);
    cs <= 1'b0;
  endtask

  task automatic load_random_block();
    for (int i = 0; i < 16; i++) begin
      bus_write(32'(`SHA256_OFF_BLOCK) + 32'(4 * i), $urandom());
    end
  endtask

  task automatic read_digest();
    logic [31:0] d;
    for (int i = 0; i < 8; i++) begin
      bus_read(32'(`SHA256_OFF_DIGEST) + 32'(4 * i), d);
    end
  endtask

  // Old VALID drops first, then the new result raises it
  task automatic wait_valid();
    logic [31:0] st;
    int          polls;
    polls = 0;
    st    = 32'h2;
    while (st[STATUS_VALID] && polls < 8) begin
      bus_read(32'(`SHA256_OFF_STATUS), st);
      polls++;
    end
    polls = 0;
    while (!st[STATUS_VALID] && polls < 200) begin
      bus_read(32'(`SHA256_OFF_STATUS), st);
      polls++;
    end
    if (!st[STATUS_VALID]) begin
      local_errors++;
      $display("STATUS.VALID did not return after a hash command");
    end
  endtask

  task automatic run_hash(input logic first, input logic mode);
    logic [31:0] ctrl;
    ctrl = '0;
    ctrl[CTRL_INIT] = first;
    ctrl[CTRL_NEXT] = !first;
    ctrl[CTRL_MODE] = mode;
    // Each completion must raise NOTIF again from a cleared state
    bus_write(32'(`SHA256_OFF_INTR), 32'h1);
    bus_write(32'(`SHA256_OFF_CTRL), ctrl);
    wait_valid();
  endtask

  function automatic int total_errors();
    return checker_inst.error_count + local_errors;
  endfunction

  task automatic end_test(input int num, input string name);
    int errs;
    errs = total_errors() - errors_before;
    if (errs == 0) tests_passed++;
    else tests_failed++;
    $display("test %0d %s: %s (%0d mismatches)", num, name, errs == 0 ? "ok" : "failed", errs);
    errors_before = total_errors();
  endtask

  // ------------------------------
  // Watchdog
  // ------------------------------
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired, the run stopped making progress");
    $display("RESULT: FAIL");
    $finish;
  end

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    logic [31:0] d;
    logic [31:0] addr;
    logic        mode;
    int          nblk;
    int          kind;
    clk        = 1'b0;
    reset_n    = 1'b0;
    cs         = 1'b0;
    we         = 1'b0;
    address    = '0;
    write_data = '0;
    seed_value = $urandom(32'hd7216fd6);
    repeat (8) @(posedge clk);
    reset_n <= 1'b1;
    errors_before = 0;

    // Identification and reset state
    for (int i = 0; i < 6; i++) begin
      bus_read(32'(4 * i), d);
    end
    bus_read(32'(`SHA256_OFF_INTR), d);
    end_test(1, "reset state");

    // Known vector "abc" first, then random SHA-256 blocks
    bus_write(32'(`SHA256_OFF_BLOCK), 32'h61626380);
    for (int i = 1; i < 16; i++) begin
      bus_write(32'(`SHA256_OFF_BLOCK) + 32'(4 * i), i == 15 ? 32'h18 : 32'h0);
    end
    run_hash(1'b1, 1'b1);
    bus_read(32'(`SHA256_OFF_DIGEST), d);
    if (d !== 32'hba7816bf) begin
      local_errors++;
      $display("ERR %0t DIGEST0 expected %08h got %08h", $time, 32'hba7816bf, d);
    end
    for (int b = 0; b < 5; b++) begin
      load_random_block();
      run_hash(1'b1, 1'b1);
      read_digest();
    end
    end_test(2, "single blocks sha256");

    // Chained messages in random mode
    for (int m = 0; m < 4; m++) begin
      nblk = 2 + $urandom_range(2);
      mode = $urandom_range(1) == 1;
      for (int b = 0; b < nblk; b++) begin
        load_random_block();
        run_hash(b == 0, mode);
      end
      read_digest();
    end
    end_test(3, "chained messages");

    // Sticky NOTIF, a 0 write keeps it and a 1 write clears it
    load_random_block();
    run_hash(1'b1, 1'b0);
    bus_read(32'(`SHA256_OFF_INTR), d);
    bus_write(32'(`SHA256_OFF_INTR), 32'h0);
    bus_read(32'(`SHA256_OFF_INTR), d);
    bus_write(32'(`SHA256_OFF_INTR), 32'h1);
    bus_read(32'(`SHA256_OFF_INTR), d);
    end_test(4, "notif interrupt");

    // Bad accesses set err and ERROR, good ones never do
    for (int i = 0; i < 24; i++) begin
      kind = $urandom_range(3);
      case (kind)
        0: addr = ($urandom() & 32'hfc) | 32'(1 + $urandom_range(2));
        1: addr = ($urandom() | 32'h100) & 32'hffff_fffc;
        2: addr = (i % 2 == 0) ? 32'h1c + 32'(4 * $urandom_range(8))
                               : 32'ha0 + 32'(4 * $urandom_range(23));
        default: addr = 32'(`SHA256_OFF_DIGEST) + 32'(4 * $urandom_range(7));
      endcase
      if (kind == 3 || $urandom_range(1) == 1) bus_write(addr, $urandom());
      else bus_read(addr, d);
      bus_read(32'(`SHA256_OFF_BLOCK) + 32'(4 * $urandom_range(15)), d);
      // Next bad access must raise ERROR from zero
      bus_write(32'(`SHA256_OFF_INTR), 32'h2);
    end
    bus_write(32'(`SHA256_OFF_STATUS), 32'h0);
    bus_write(32'(`SHA256_OFF_NAME), 32'h0);
    bus_read(32'(`SHA256_OFF_INTR), d);
    bus_write(32'(`SHA256_OFF_INTR), 32'h2);
    bus_read(32'(`SHA256_OFF_INTR), d);
    end_test(5, "bus errors");

    // Zeroize clears the block, the digest and VALID
    load_random_block();
    bus_write(32'(`SHA256_OFF_CTRL), 32'h8);
    repeat (4) @(posedge clk);
    for (int i = 0; i < 16; i++) begin
      bus_read(32'(`SHA256_OFF_BLOCK) + 32'(4 * i), d);
    end
    read_digest();
    bus_read(32'(`SHA256_OFF_STATUS), d);
    load_random_block();
    run_hash(1'b1, 1'b1);
    read_digest();
    end_test(6, "zeroize");

    $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && total_errors() == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+include
hw/sha256_core_pkg.sv
hw/sha256_reg_pkg.sv
hw/sha256_w_mem.sv
hw/sha256_core.sv
hw/sha256_regs.sv
hw/sha256.sv
bench/sha256_properties.sv
bench/sha256_checker.sv
bench/sha256_tb.sv

// ==== Makefile ====
SRCS := $(wildcard hw/*.sv bench/*.sv include/*.svh) sim.f

.PHONY: all run clean

all: obj_dir/Vsha256_tb

obj_dir/Vsha256_tb: $(SRCS)
	verilator --binary --timing --assert --top-module sha256_tb -f sim.f -o Vsha256_tb

run: obj_dir/Vsha256_tb
	@out=$$(./obj_dir/Vsha256_tb); \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir
